/* source/spi_flash_pkg.sv */
`default_nettype none

package spi_flash_pkg;

	// Bus and flash widths.
	localparam int DATA_BITS = 16;
	localparam int BUS_ADDR_BITS = 8;
	localparam int FLASH_ADDR_BITS = 24;

	// Word address is one bit shorter than the byte address.
	localparam int WORD_ADDR_BITS = FLASH_ADDR_BITS - 1;
	localparam int ADDR_HI_BITS = WORD_ADDR_BITS - DATA_BITS;

	// Bit timing in system clocks.
	localparam int TICKS_PER_BIT = 8;
	localparam int TICK_BITS = $clog2(TICKS_PER_BIT);
	localparam int SCK_RISE_TICK = 4;	// SCK rises and MISO is sampled here.

	// Phase lengths in bits.
	localparam int CMD_BITS = 8;
	localparam int ADDR_PHASE_BITS = 24;
	localparam int DATA_PHASE_BITS = 16;
	localparam int BIT_CNT_BITS = $clog2(ADDR_PHASE_BITS);

	// Register map.
	typedef enum logic [BUS_ADDR_BITS-1:0] {
		REG_ADDR_LO = 8'h00,	// Word address bits 15..0.
		REG_ADDR_HI = 8'h01,	// Word address bits 22..16 in bits 6..0.
		REG_CMD = 8'h02,	// Bit 0 read, bit 1 wake.
		REG_DATA = 8'h03,
		REG_STATUS = 8'h04	// Bit 0 done.
	} reg_addr_t;

	// Flash opcodes.
	typedef enum logic [CMD_BITS-1:0] {
		FLASH_READ = 8'h03,
		FLASH_WAKE = 8'hAB	// Release from power-down.
	} flash_cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		SEND_CMD,
		SEND_ADDR,
		GET_DATA,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

/* source/spi_cmd_if.sv */
`default_nettype none

interface spi_cmd_if;
	import spi_flash_pkg::*;

	logic read_go;	// One-cycle start pulses.
	logic wake_go;
	logic [WORD_ADDR_BITS-1:0] word_addr;

	logic [DATA_BITS-1:0] rd_data;	// Word as shifted in, first byte on top.
	logic done;	// Pulses for the one cycle spent in DONE.

	modport regs (
		output read_go,
		output wake_go,
		output word_addr,
		input rd_data,
		input done
	);

	modport seq (
		input read_go,
		input wake_go,
		input word_addr,
		output rd_data,
		output done
	);

endinterface

`default_nettype wire

/* source/spi_flash_regs.sv */
`default_nettype none

module spi_flash_regs (
	input wire logic CLK,
	input wire logic RSTb,
	input wire spi_flash_pkg::reg_addr_t addr,
	input wire logic [spi_flash_pkg::DATA_BITS-1:0] wr_data,
	output logic [spi_flash_pkg::DATA_BITS-1:0] rd_data,
	input wire logic wr,
	spi_cmd_if.regs cmd
);
	import spi_flash_pkg::*;

	logic [DATA_BITS-1:0] addr_lo;
	logic [ADDR_HI_BITS-1:0] addr_hi;
	logic done_flag;

	logic wr_lo;
	logic wr_hi;
	logic wr_cmd;
	logic cmd_any;

	assign wr_lo = wr && (addr == REG_ADDR_LO);
	assign wr_hi = wr && (addr == REG_ADDR_HI);
	assign wr_cmd = wr && (addr == REG_CMD);
	assign cmd_any = wr_cmd && (wr_data[1] || wr_data[0]);

	assign cmd.word_addr = {addr_hi, addr_lo};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			addr_lo <= '0;
			addr_hi <= '0;
		end else begin
			if (wr_lo)
				addr_lo <= wr_data;
			if (wr_hi)
				addr_hi <= wr_data[ADDR_HI_BITS-1:0];	// Upper bits are dropped.
		end
	end

	// Command writes become single-cycle go pulses.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cmd.read_go <= 1'b0;
			cmd.wake_go <= 1'b0;
		end else begin
			cmd.read_go <= wr_cmd && wr_data[0];
			cmd.wake_go <= wr_cmd && wr_data[1];
		end
	end

	// Sticky done. A command write clears it at once, and wins over a done
	// pulse arriving on the same edge since that command is the one accepted.
	always_ff @(posedge CLK) begin
		if (!RSTb)
			done_flag <= 1'b0;
		else if (cmd_any)
			done_flag <= 1'b0;
		else if (cmd.done)
			done_flag <= 1'b1;
	end

	always_comb begin
		rd_data = '0;
		case (addr)
			REG_DATA:	// First flash byte goes to the low byte.
				rd_data = {cmd.rd_data[DATA_BITS/2-1:0], cmd.rd_data[DATA_BITS-1:DATA_BITS/2]};
			REG_STATUS:
				rd_data = {{(DATA_BITS-1){1'b0}}, done_flag};
			default:
				rd_data = '0;
		endcase
	end

	// Go pulses last one cycle, so no two start requests arrive back to back.
	a_go_single: assert property (
		@(posedge CLK) disable iff (!RSTb)
		(cmd.read_go || cmd.wake_go) |=> !(cmd.read_go || cmd.wake_go)
	);

endmodule

`default_nettype wire

/* source/spi_sck_gen.sv */
`default_nettype none

module spi_sck_gen (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic run,
	input wire logic phase_restart,
	output logic sck,
	output logic sample_stb,
	output logic bit_end
);
	import spi_flash_pkg::*;

	logic [TICK_BITS-1:0] tick;

	// Tick counter wraps naturally at the end of each bit period.
	always_ff @(posedge CLK) begin
		if (!RSTb)
			tick <= '0;
		else if (phase_restart)
			tick <= '0;
		else if (run)
			tick <= tick + 1'b1;
	end

	assign sample_stb = run && (tick == TICK_BITS'(SCK_RISE_TICK));
	assign bit_end = run && (tick == TICK_BITS'(TICKS_PER_BIT - 1));

	// Mode 0 clock. Low for the first half of the bit, high for the second.
	always_ff @(posedge CLK) begin
		if (!RSTb)
			sck <= 1'b0;
		else if (!run || phase_restart || bit_end)
			sck <= 1'b0;
		else if (sample_stb)
			sck <= 1'b1;
	end

	a_stb_apart: assert property (
		@(posedge CLK) disable iff (!RSTb)
		!(sample_stb && bit_end)
	);

endmodule

`default_nettype wire

/* source/spi_flash_seq.sv */
`default_nettype none

module spi_flash_seq (
	input wire logic CLK,
	input wire logic RSTb,
	spi_cmd_if.seq cmd,
	output logic run,
	output logic phase_restart,
	input wire logic sample_stb,
	input wire logic bit_end,
	input wire logic miso,
	output logic mosi,
	output logic csb
);
	import spi_flash_pkg::*;

	seq_state_t state;
	logic [FLASH_ADDR_BITS-1:0] shift_r;
	logic [BIT_CNT_BITS-1:0] bit_cnt;
	logic [BIT_CNT_BITS-1:0] last_bit;
	logic read_op;	// Set for a read, clear for a wake.
	logic start;
	logic phase_done;
	flash_cmd_t opcode;

	// Go pulses are only taken in IDLE. Read has priority.
	assign start = (state == IDLE) && (cmd.read_go || cmd.wake_go);
	assign opcode = cmd.read_go ? FLASH_READ : FLASH_WAKE;

	always_comb begin
		case (state)
			SEND_CMD:
				last_bit = BIT_CNT_BITS'(CMD_BITS - 1);
			SEND_ADDR:
				last_bit = BIT_CNT_BITS'(ADDR_PHASE_BITS - 1);
			default:
				last_bit = BIT_CNT_BITS'(DATA_PHASE_BITS - 1);
		endcase
	end

	assign phase_done = bit_end && (bit_cnt == last_bit);

	assign run = (state == SEND_CMD) || (state == SEND_ADDR) || (state == GET_DATA);
	assign phase_restart = start
		|| (phase_done && (state == SEND_CMD) && read_op)
		|| (phase_done && (state == SEND_ADDR));

	assign mosi = ((state == SEND_CMD) || (state == SEND_ADDR)) ?
		shift_r[FLASH_ADDR_BITS-1] : 1'b0;
	assign csb = !run;	// Selected only while bits are moving.
	assign cmd.done = (state == DONE);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= IDLE;
			bit_cnt <= '0;
			read_op <= 1'b0;
		end else begin
			case (state)
				IDLE:
					if (start) begin
						state <= SEND_CMD;
						read_op <= cmd.read_go;
						bit_cnt <= '0;
					end
				SEND_CMD, SEND_ADDR, GET_DATA:
					if (phase_done) begin
						bit_cnt <= '0;
						if (state == SEND_CMD)
							state <= read_op ? SEND_ADDR : DONE;
						else if (state == SEND_ADDR)
							state <= GET_DATA;
						else
							state <= DONE;
					end else if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				DONE:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Outgoing shifter. Opcode sits in the top byte, then the byte address.
	always_ff @(posedge CLK) begin
		if (start)
			shift_r <= {opcode, {(FLASH_ADDR_BITS-CMD_BITS){1'b0}}};
		else if (phase_done && (state == SEND_CMD))
			shift_r <= {cmd.word_addr, 1'b0};
		else if (bit_end)
			shift_r <= {shift_r[FLASH_ADDR_BITS-2:0], 1'b0};
	end

	// Read data holds until the next read reaches its data phase.
	always_ff @(posedge CLK) begin
		if (!RSTb)
			cmd.rd_data <= '0;
		else if ((state == GET_DATA) && sample_stb)
			cmd.rd_data <= {cmd.rd_data[DATA_BITS-2:0], miso};
	end

	a_idle_deselect: assert property (
		@(posedge CLK) disable iff (!RSTb)
		(state == IDLE) |-> csb
	);

endmodule

`default_nettype wire

/* source/spi_flash_top.sv */
`default_nettype none

module spi_flash_top (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic [spi_flash_pkg::BUS_ADDR_BITS-1:0] addr,
	input wire logic [spi_flash_pkg::DATA_BITS-1:0] wr_data,
	input wire logic wr,
	output logic [spi_flash_pkg::DATA_BITS-1:0] rd_data,
	output logic mosi,
	output logic sck,
	output logic csb,
	input wire logic miso
);
	import spi_flash_pkg::*;

	logic run;
	logic phase_restart;
	logic sample_stb;
	logic bit_end;

	spi_cmd_if cmd_if ();

	spi_flash_regs spi_flash_regs_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.addr(reg_addr_t'(addr)),	// Unmapped values fall to the default read.
		.wr_data(wr_data),
		.rd_data(rd_data),
		.wr(wr),
		.cmd(cmd_if.regs)
	);

	spi_flash_seq spi_flash_seq_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.cmd(cmd_if.seq),
		.run(run),
		.phase_restart(phase_restart),
		.sample_stb(sample_stb),
		.bit_end(bit_end),
		.miso(miso),
		.mosi(mosi),
		.csb(csb)
	);

	spi_sck_gen spi_sck_gen_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.run(run),
		.phase_restart(phase_restart),
		.sck(sck),
		.sample_stb(sample_stb),
		.bit_end(bit_end)
	);

endmodule

`default_nettype wire

/* tb/tb_flash_model.sv */
`default_nettype none

module tb_flash_model (
	input wire logic csb,
	input wire logic sck,
	input wire logic mosi,
	output logic miso,
	output logic bad_transfer,
	output int wake_count,
	output int read_count,
	output int last_edges
);
	import spi_flash_pkg::*;

	localparam int READ_EDGES = CMD_BITS + ADDR_PHASE_BITS + DATA_PHASE_BITS;

	logic selected;
	int edges;	// SCK rising edges in the current frame.
	int addr_bits;
	logic [CMD_BITS-1:0] opcode;
	logic [FLASH_ADDR_BITS-1:0] byte_addr;
	logic [DATA_BITS-1:0] out_word;

	// XOR of the three address bytes, plus 5Ah.
	function automatic logic [7:0] stored_byte(input logic [FLASH_ADDR_BITS-1:0] a);
		return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
	endfunction

	task automatic report_bad(input string msg);
		$display("Flash model error: %s", msg);
		bad_transfer = 1'b1;
	endtask

	initial begin
		miso = 1'b0;
		bad_transfer = 1'b0;
		selected = 1'b0;
		wake_count = 0;
		read_count = 0;
		last_edges = 0;
	end

	always @(negedge csb) begin
		if (csb === 1'b0) begin
			selected = 1'b1;
			edges = 0;
			addr_bits = 0;
			opcode = '0;
			byte_addr = '0;
		end
	end

	// Mode 0, so MOSI is taken on the rising edge.
	always @(posedge sck) begin
		if (!selected) begin
			report_bad("SCK rose while the chip was not selected.");
		end else begin
			edges = edges + 1;
			if (edges <= CMD_BITS) begin
				opcode = {opcode[CMD_BITS-2:0], mosi};
				if (edges == CMD_BITS && opcode != FLASH_READ && opcode != FLASH_WAKE)
					report_bad($sformatf("unknown opcode %h.", opcode));
			end else if (opcode == FLASH_READ && addr_bits < ADDR_PHASE_BITS) begin
				byte_addr = {byte_addr[FLASH_ADDR_BITS-2:0], mosi};
				addr_bits = addr_bits + 1;
				if (addr_bits == ADDR_PHASE_BITS)
					out_word = {stored_byte(byte_addr), stored_byte(byte_addr + 1'b1)};
			end
		end
	end

	// Data goes out on the falling edge, first byte MSB first.
	always @(negedge sck) begin
		if (selected && opcode == FLASH_READ && addr_bits == ADDR_PHASE_BITS
				&& edges < READ_EDGES)
			miso <= out_word[READ_EDGES - 1 - edges];
	end

	always @(posedge csb) begin
		if (selected) begin
			selected = 1'b0;
			last_edges = edges;
			miso <= 1'b0;
			if (opcode == FLASH_WAKE) begin
				if (edges != CMD_BITS)
					report_bad($sformatf("wake frame had %0d SCK edges.", edges));
				else
					wake_count = wake_count + 1;
			end else if (opcode == FLASH_READ) begin
				if (addr_bits != ADDR_PHASE_BITS)
					report_bad($sformatf("address phase had %0d bits.", addr_bits));
				else if (edges != READ_EDGES)
					report_bad($sformatf("read frame had %0d SCK edges.", edges));
				else
					read_count = read_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

/* tb/spi_flash_tb.sv */
`default_nettype none

module spi_flash_tb;
	import spi_flash_pkg::*;

	localparam int NUM_READS = 24;
	localparam int NUM_WAKES = 1;
	localparam int CYCLE_LIMIT = (NUM_READS * 400 + NUM_WAKES * 80) * 3 / 2 + 1000;
	localparam int READ_EDGES = CMD_BITS + ADDR_PHASE_BITS + DATA_PHASE_BITS;
	localparam logic [WORD_ADDR_BITS-1:0] MAX_WORD = '1;
	localparam logic [DATA_BITS-1:0] CMD_READ = 16'h0001;
	localparam logic [DATA_BITS-1:0] CMD_WAKE = 16'h0002;
	localparam logic [DATA_BITS-1:0] CMD_BOTH = 16'h0003;

	logic CLK;
	logic RSTb;
	logic [BUS_ADDR_BITS-1:0] addr;
	logic [DATA_BITS-1:0] wr_data;
	logic wr;
	logic [DATA_BITS-1:0] rd_data;
	logic mosi;
	logic sck;
	logic csb;
	logic miso;
	logic bad_transfer;
	int wake_count;
	int read_count;
	int last_edges;
	int cycles = 0;
	int seed;

	// Pending word compares, drained at the next rising edge.
	string what_q[$];
	logic [DATA_BITS-1:0] got_q[$];
	logic [DATA_BITS-1:0] exp_q[$];

	spi_flash_top spi_flash_top_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.addr(addr),
		.wr_data(wr_data),
		.wr(wr),
		.rd_data(rd_data),
		.mosi(mosi),
		.sck(sck),
		.csb(csb),
		.miso(miso)
	);

	tb_flash_model flash_model_i (
		.csb(csb),
		.sck(sck),
		.mosi(mosi),
		.miso(miso),
		.bad_transfer(bad_transfer),
		.wake_count(wake_count),
		.read_count(read_count),
		.last_edges(last_edges)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	task automatic stop_with_failure(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input string what, input logic [DATA_BITS-1:0] got,
			input logic [DATA_BITS-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s is %h, expected %h", what, got, exp);
			stop_with_failure("Stopped at the first failed check.");
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s is %h, expected %h", what, got, exp);
			stop_with_failure("Stopped at the first failed check.");
		end
	endtask

	task automatic check_pin(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s is %h, expected %h", what, got, exp);
			stop_with_failure("Stopped at the first failed check.");
		end
	endtask

	function automatic logic [7:0] flash_byte(input logic [FLASH_ADDR_BITS-1:0] a);
		return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
	endfunction

	// Byte 2W lands in the low byte, byte 2W+1 in the high byte.
	function automatic logic [DATA_BITS-1:0] flash_word(input logic [WORD_ADDR_BITS-1:0] w);
		return {flash_byte({w, 1'b1}), flash_byte({w, 1'b0})};
	endfunction

	task automatic queue_check(input string what, input logic [DATA_BITS-1:0] got,
			input logic [DATA_BITS-1:0] exp);
		what_q.push_back(what);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	task automatic bus_write(input reg_addr_t a, input logic [DATA_BITS-1:0] d);
		@(negedge CLK);
		addr = a;
		wr_data = d;
		wr = 1'b1;
		@(negedge CLK);
		wr = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t a, output logic [DATA_BITS-1:0] d);
		@(negedge CLK);
		addr = a;
		wr = 1'b0;
		@(negedge CLK);
		d = rd_data;
	endtask

	task automatic start_cmd(input logic [DATA_BITS-1:0] bits);
		logic [DATA_BITS-1:0] status;
		bus_write(REG_CMD, bits);
		bus_read(REG_STATUS, status);
		queue_check("REG_STATUS after command", status, '0);	// Done must clear.
	endtask

	task automatic wait_done();
		logic [DATA_BITS-1:0] status;
		status = '0;
		while (status[0] !== 1'b1)
			bus_read(REG_STATUS, status);
	endtask

	task automatic run_read(input logic [WORD_ADDR_BITS-1:0] w,
			input logic [DATA_BITS-1:0] bits, input logic poke_wake);
		logic [DATA_BITS-1:0] word;
		int reads_before;
		int wakes_before;
		reads_before = read_count;
		wakes_before = wake_count;
		bus_write(REG_ADDR_LO, w[DATA_BITS-1:0]);
		bus_write(REG_ADDR_HI, DATA_BITS'(w >> DATA_BITS));
		start_cmd(bits);
		if (poke_wake)
			bus_write(REG_CMD, CMD_WAKE);	// Lands while the read is busy.
		wait_done();
		bus_read(REG_DATA, word);
		queue_check($sformatf("REG_DATA for word %h", w), word, flash_word(w));
		check_count("flash read count", read_count, reads_before + 1);
		check_count("flash wake count", wake_count, wakes_before);
		check_count("SCK edges per read", last_edges, READ_EDGES);
	endtask

	always @(posedge CLK) begin
		while (got_q.size() > 0)
			check_word(what_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			stop_with_failure($sformatf("Timeout, no finish within %0d cycles.", CYCLE_LIMIT));
	end

	always @(posedge bad_transfer)
		stop_with_failure("The flash model saw a bad SPI transfer.");

	initial begin
		logic [DATA_BITS-1:0] word;
		logic [WORD_ADDR_BITS-1:0] w;
		int wakes_before;

		seed = 12015;
		RSTb = 1'b0;
		addr = '0;
		wr_data = '0;
		wr = 1'b0;
		w = '0;
		repeat (2) @(negedge CLK);
		RSTb = 1'b1;

		check_pin("csb", csb, 1'b1);
		check_pin("sck", sck, 1'b0);
		check_pin("mosi", mosi, 1'b0);
		bus_read(REG_STATUS, word);
		queue_check("REG_STATUS after reset", word, '0);
		bus_read(REG_ADDR_LO, word);
		queue_check("REG_ADDR_LO after reset", word, '0);
		bus_read(REG_ADDR_HI, word);
		queue_check("REG_ADDR_HI after reset", word, '0);
		bus_read(REG_DATA, word);
		queue_check("REG_DATA after reset", word, '0);
		check_count("flash read count", read_count, 0);

		run_read('0, CMD_READ, 1'b0);
		run_read(MAX_WORD, CMD_READ, 1'b0);

		repeat (20) begin
			w = WORD_ADDR_BITS'($random(seed));
			run_read(w, CMD_READ, 1'b0);
		end

		// Wake leaves the last read word in place.
		wakes_before = wake_count;
		start_cmd(CMD_WAKE);
		wait_done();
		check_count("flash wake count", wake_count, wakes_before + 1);
		check_count("SCK edges per wake", last_edges, CMD_BITS);
		bus_read(REG_DATA, word);
		queue_check("REG_DATA after wake", word, flash_word(w));

		run_read(WORD_ADDR_BITS'($random(seed)), CMD_READ, 1'b1);
		run_read(WORD_ADDR_BITS'($random(seed)), CMD_BOTH, 1'b0);

		while (got_q.size() != 0)
			@(negedge CLK);
		@(negedge CLK);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* spi_flash.f */
source/spi_flash_pkg.sv
source/spi_cmd_if.sv
source/spi_flash_regs.sv
source/spi_sck_gen.sv
source/spi_flash_seq.sv
source/spi_flash_top.sv
tb/tb_flash_model.sv
tb/spi_flash_tb.sv
